// File: lsq_pkg.sv
package lsq_pkg;

    localparam int XLEN       = 32;
    localparam int ROB_TAG_W  = 5;
    localparam int OFFSET_W   = 12;
    localparam int LSQ_DEPTH  = 8;
    localparam int LSQ_PTR_W  = 3;
    localparam int MEM_WORDS  = 64;
    localparam int MEM_ADDR_W = 6;

    typedef enum logic {
        ls_load  = 1'b0,
        ls_store = 1'b1
    } ls_op_e;

    // source operand as seen by the queue.
    typedef struct packed {
        logic [ROB_TAG_W-1:0] tag;   // producer tag.
        logic                 ready; // value valid.
        logic [XLEN-1:0]      value;
    } operand_t;

    typedef struct packed {
        ls_op_e                     op;
        logic [ROB_TAG_W-1:0]       rob_tag;
        operand_t                   base;
        operand_t                   data;   // store data, unused for loads.
        logic signed [OFFSET_W-1:0] offset;
    } ls_insn_t;

    typedef struct packed {
        logic                 valid;
        logic [ROB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      value;
    } cdb_t;

    // resolved operation handed to the unit.
    typedef struct packed {
        ls_op_e                     op;
        logic [ROB_TAG_W-1:0]       rob_tag;
        logic [XLEN-1:0]            base;
        logic [XLEN-1:0]            data;
        logic signed [OFFSET_W-1:0] offset;
    } ls_req_t;

    typedef struct packed {
        logic [ROB_TAG_W-1:0] rob_tag;
        logic [XLEN-1:0]      value;
    } wb_t;

endpackage

// File: ls_queue.sv
`timescale 1ns/1ps

module ls_queue (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          flush,
    input  logic                          dispatch_valid,
    input  lsq_pkg::ls_insn_t             dispatch_insn,
    output logic                          dispatch_ready,
    input  lsq_pkg::cdb_t                 cdb,
    input  logic                          commit_valid,
    input  logic [lsq_pkg::ROB_TAG_W-1:0] commit_tag,
    output logic                          issue_valid,
    output lsq_pkg::ls_req_t              issue_req,
    input  logic                          issue_ready
);

    lsq_pkg::ls_insn_t             entry [lsq_pkg::LSQ_DEPTH];
    logic [lsq_pkg::LSQ_DEPTH-1:0] entry_valid;
    logic [lsq_pkg::LSQ_DEPTH-1:0] entry_committed;
    logic [lsq_pkg::LSQ_PTR_W-1:0] head;
    logic [lsq_pkg::LSQ_PTR_W-1:0] tail;
    logic [lsq_pkg::LSQ_PTR_W:0]   count;

    lsq_pkg::ls_insn_t head_entry;
    lsq_pkg::ls_insn_t new_entry;
    logic              new_committed;
    logic              head_ok;
    logic              push;
    logic              pop;

    // capture a matching broadcast into a waiting operand.
    function automatic lsq_pkg::operand_t wake(input lsq_pkg::operand_t opnd,
                                               input lsq_pkg::cdb_t     bcast);
        lsq_pkg::operand_t res;
        res = opnd;
        if (!opnd.ready && bcast.valid && (bcast.tag == opnd.tag)) begin
            res.ready = 1'b1;
            res.value = bcast.value;
        end
        return res;
    endfunction

    assign push = dispatch_valid && dispatch_ready;
    assign pop  = issue_valid && issue_ready;

    assign dispatch_ready = (count != (lsq_pkg::LSQ_PTR_W + 1)'(lsq_pkg::LSQ_DEPTH));

    // dispatch path sees the cdb in the same cycle.
    always_comb begin
        new_entry      = dispatch_insn;
        new_entry.base = wake(dispatch_insn.base, cdb);
        new_entry.data = wake(dispatch_insn.data, cdb);
    end

    // commit may name a store in its dispatch cycle.
    assign new_committed = commit_valid
                           && (dispatch_insn.op == lsq_pkg::ls_store)
                           && (dispatch_insn.rob_tag == commit_tag);

    assign head_entry = entry[head];

    always_comb begin
        head_ok = entry_valid[head] && head_entry.base.ready;
        if (head_entry.op == lsq_pkg::ls_store) begin
            head_ok = head_ok && head_entry.data.ready && entry_committed[head];
        end
    end

    assign issue_valid = head_ok;

    always_comb begin
        issue_req.op      = head_entry.op;
        issue_req.rob_tag = head_entry.rob_tag;
        issue_req.base    = head_entry.base.value;
        issue_req.data    = head_entry.data.value;
        issue_req.offset  = head_entry.offset;
    end

    // entry payload, operands wake independently.
    always_ff @(posedge clk) begin
        for (int i = 0; i < lsq_pkg::LSQ_DEPTH; i++) begin
            entry[i].base <= wake(entry[i].base, cdb);
            entry[i].data <= wake(entry[i].data, cdb);
        end
        if (push) begin
            entry[tail] <= new_entry; // overrides the wakeup above.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry_valid     <= '0;
            entry_committed <= '0;
            head            <= '0;
            tail            <= '0;
            count           <= '0;
        end else if (flush) begin
            entry_valid     <= '0;
            entry_committed <= '0;
            head            <= '0;
            tail            <= '0;
            count           <= '0;
        end else begin
            for (int i = 0; i < lsq_pkg::LSQ_DEPTH; i++) begin
                if (commit_valid && entry_valid[i]
                    && (entry[i].op == lsq_pkg::ls_store)
                    && (entry[i].rob_tag == commit_tag)) begin
                    entry_committed[i] <= 1'b1;
                end
            end
            if (pop) begin
                entry_valid[head]     <= 1'b0;
                entry_committed[head] <= 1'b0;
                head                  <= head + 1'b1; // wraps at depth.
            end
            if (push) begin
                entry_valid[tail]     <= 1'b1;
                entry_committed[tail] <= new_committed;
                tail                  <= tail + 1'b1;
            end
            count <= count + (lsq_pkg::LSQ_PTR_W + 1)'(push)
                           - (lsq_pkg::LSQ_PTR_W + 1)'(pop);
        end
    end

endmodule

// File: ls_unit.sv
`timescale 1ns/1ps

module ls_unit (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           issue_valid,
    input  lsq_pkg::ls_req_t               issue_req,
    output logic                           issue_ready,
    output logic                           mem_en,
    output logic                           mem_we,
    output logic [lsq_pkg::MEM_ADDR_W-1:0] mem_addr,
    output logic [lsq_pkg::XLEN-1:0]       mem_wdata,
    input  logic [lsq_pkg::XLEN-1:0]       mem_rdata,
    output logic                           wb_valid,
    output lsq_pkg::wb_t                   wb,
    input  logic                           wb_ready
);

    logic                          s1_valid;
    lsq_pkg::ls_req_t              s1_req;
    logic [lsq_pkg::XLEN-1:0]      s1_addr;
    logic                          s2_valid;
    logic [lsq_pkg::ROB_TAG_W-1:0] s2_tag;
    logic                          wb_free;
    logic                          s2_free;

    assign wb_free = !wb_valid || wb_ready;
    assign s2_free = !s2_valid || wb_free;

    // stage one moves only when stage two can take it.
    assign issue_ready = !s1_valid || s2_free;

    assign s1_addr = s1_req.base
                     + {{(lsq_pkg::XLEN - lsq_pkg::OFFSET_W){s1_req.offset[lsq_pkg::OFFSET_W-1]}},
                        s1_req.offset};

    // no access while stalled, so mem_rdata holds.
    assign mem_en    = s1_valid && s2_free;
    assign mem_we    = (s1_req.op == lsq_pkg::ls_store);
    assign mem_addr  = s1_addr[lsq_pkg::MEM_ADDR_W+1:2]; // word index.
    assign mem_wdata = s1_req.data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else if (issue_ready) begin
            s1_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            s1_req <= issue_req;
        end
    end

    // read in flight, data shows on mem_rdata.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid <= 1'b0;
        end else if (s2_free) begin
            s2_valid <= s1_valid && (s1_req.op == lsq_pkg::ls_load);
        end
    end

    always_ff @(posedge clk) begin
        if (mem_en) begin
            s2_tag <= s1_req.rob_tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else if (wb_free) begin
            wb_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_free && s2_valid) begin
            wb.rob_tag <= s2_tag;
            wb.value   <= mem_rdata;
        end
    end

endmodule

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           mem_en,
    input  logic                           mem_we,
    input  logic [lsq_pkg::MEM_ADDR_W-1:0] mem_addr,
    input  logic [lsq_pkg::XLEN-1:0]       mem_wdata,
    output logic [lsq_pkg::XLEN-1:0]       mem_rdata
);

    logic [lsq_pkg::XLEN-1:0] mem [lsq_pkg::MEM_WORDS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < lsq_pkg::MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_en && mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // only a read updates the output.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_rdata <= '0;
        end else if (mem_en && !mem_we) begin
            mem_rdata <= mem[mem_addr]; // old content.
        end
    end

endmodule

// File: lsq_top.sv
`timescale 1ns/1ps

module lsq_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          flush,
    input  logic                          dispatch_valid,
    input  lsq_pkg::ls_insn_t             dispatch_insn,
    output logic                          dispatch_ready,
    input  lsq_pkg::cdb_t                 cdb,
    input  logic                          commit_valid,
    input  logic [lsq_pkg::ROB_TAG_W-1:0] commit_tag,
    output logic                          wb_valid,
    output lsq_pkg::wb_t                  wb,
    input  logic                          wb_ready
);

    logic                           issue_valid;
    logic                           issue_ready;
    lsq_pkg::ls_req_t               issue_req;
    logic                           mem_en;
    logic                           mem_we;
    logic [lsq_pkg::MEM_ADDR_W-1:0] mem_addr;
    logic [lsq_pkg::XLEN-1:0]       mem_wdata;
    logic [lsq_pkg::XLEN-1:0]       mem_rdata;

    ls_queue u_queue (
        .clk            (clk),
        .arst_n         (arst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_insn  (dispatch_insn),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb),
        .commit_valid   (commit_valid),
        .commit_tag     (commit_tag),
        .issue_valid    (issue_valid),
        .issue_req      (issue_req),
        .issue_ready    (issue_ready)
    );

    ls_unit u_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .issue_ready (issue_ready),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .wb_ready    (wb_ready)
    );

    data_mem u_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: lsq_tb_clk.sv
`timescale 1ns/1ps

module lsq_tb_clk (
    output logic clk,
    output logic arst_n
);

    localparam time HALF_PERIOD = 20ns;

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1; // released between edges.
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: lsq_assert.sv
`timescale 1ns/1ps

module lsq_assert (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          flush,
    input logic                          dispatch_ready,
    input logic                          issue_valid,
    input logic                          issue_ready,
    input lsq_pkg::ls_req_t              issue_req,
    input logic                          commit_valid,
    input logic [lsq_pkg::ROB_TAG_W-1:0] commit_tag,
    input logic [lsq_pkg::LSQ_DEPTH-1:0] entry_valid
);

    logic [(1 << lsq_pkg::ROB_TAG_W)-1:0] commit_seen; // committed, not yet issued.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_seen <= '0;
        end else if (flush) begin
            commit_seen <= '0;
        end else begin
            if (issue_valid && issue_ready && (issue_req.op == lsq_pkg::ls_store)) begin
                commit_seen[issue_req.rob_tag] <= 1'b0;
            end
            if (commit_valid) begin
                commit_seen[commit_tag] <= 1'b1;
            end
        end
    end

    store_needs_commit: assert property (@(posedge clk) disable iff (!arst_n)
        issue_valid && (issue_req.op == lsq_pkg::ls_store)
        |-> commit_seen[issue_req.rob_tag])
        else $error("store issued without commit");

    full_blocks_dispatch: assert property (@(posedge clk) disable iff (!arst_n)
        ($countones(entry_valid) == lsq_pkg::LSQ_DEPTH) |-> !dispatch_ready)
        else $error("dispatch_ready high while queue full");

    // a stalled request may not change under the unit.
    issue_held: assert property (@(posedge clk) disable iff (!arst_n)
        issue_valid && !issue_ready && !flush |=> issue_valid && $stable(issue_req))
        else $error("issue_req changed while stalled");

endmodule

bind ls_queue lsq_assert u_assert (
    .clk            (clk),
    .arst_n         (arst_n),
    .flush          (flush),
    .dispatch_ready (dispatch_ready),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .issue_req      (issue_req),
    .commit_valid   (commit_valid),
    .commit_tag     (commit_tag),
    .entry_valid    (entry_valid)
);

// File: lsq_tb.sv
`timescale 1ns/1ps

module lsq_tb;

    localparam int TIMEOUT = 400;

    logic                          clk;
    logic                          arst_n;
    logic                          flush;
    logic                          dispatch_valid;
    lsq_pkg::ls_insn_t             dispatch_insn;
    logic                          dispatch_ready;
    lsq_pkg::cdb_t                 cdb;
    logic                          commit_valid;
    logic [lsq_pkg::ROB_TAG_W-1:0] commit_tag;
    logic                          wb_valid;
    lsq_pkg::wb_t                  wb;
    logic                          wb_ready;

    logic [31:0] rnd_state;
    logic [31:0] bp_state;
    logic        bp_en;
    int          wb_count;
    logic [4:0]  next_rob;
    logic [4:0]  next_tag;
    logic [31:0] model_mem [lsq_pkg::MEM_WORDS];
    logic [4:0]  exp_tag [$];
    logic [31:0] exp_val [$];
    logic [4:0]  pend_tag [$];
    logic [31:0] pend_val [$];
    logic [4:0]  commit_q [$];

    lsq_tb_clk u_clk (.clk(clk), .arst_n(arst_n));

    lsq_top UUT (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1.
    endfunction

    task automatic get_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            rnd_state = lfsr_next(rnd_state);
            r = {r[30:0], rnd_state[0]};
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // handshake sampled before the edge updates it.
    always @(posedge clk) begin
        if (arst_n && wb_valid && wb_ready) begin
            if (exp_tag.size() == 0) begin
                $display("writeback arrived with no load outstanding");
                $display("TEST RESULT: FAIL");
                $fatal(1);
            end
            check("wb.rob_tag", 32'(wb.rob_tag), 32'(exp_tag.pop_front()));
            check("wb.value", wb.value, exp_val.pop_front());
            wb_count++;
        end
    end

    always @(negedge clk) begin
        if (bp_en) begin
            bp_state = lfsr_next(bp_state);
            wb_ready = bp_state[0];
        end else begin
            wb_ready = 1'b1;
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic send_op(input logic is_store, input logic [31:0] base_v,
                           input logic [31:0] data_v, input logic [11:0] off,
                           input logic b_rdy, input logic d_rdy, input logic cdb_b,
                           input logic cdb_d, input logic track);
        logic [4:0]  bt;
        logic [4:0]  dt;
        logic [31:0] addr;
        int          t;
        bt = next_tag;
        dt = next_tag + 5'd1;
        next_tag += 5'd2;
        t = 0;
        while (!dispatch_ready) begin
            t++;
            if (t > TIMEOUT) give_up("dispatch_ready");
            @(negedge clk);
        end
        dispatch_valid              = 1'b1;
        dispatch_insn.op            = is_store ? lsq_pkg::ls_store : lsq_pkg::ls_load;
        dispatch_insn.rob_tag       = next_rob;
        dispatch_insn.base.tag      = bt;
        dispatch_insn.base.ready    = b_rdy;
        dispatch_insn.base.value    = b_rdy ? base_v : ~base_v; // stale value if waiting.
        dispatch_insn.data.tag      = dt;
        dispatch_insn.data.ready    = d_rdy || !is_store;
        dispatch_insn.data.value    = (d_rdy || !is_store) ? data_v : ~data_v;
        dispatch_insn.offset        = off;
        cdb.valid = 1'b0;
        if (cdb_b && !b_rdy) begin
            cdb.valid = 1'b1;
            cdb.tag   = bt;
            cdb.value = base_v;
        end else if (cdb_d && !d_rdy && is_store) begin
            cdb.valid = 1'b1;
            cdb.tag   = dt;
            cdb.value = data_v;
        end
        if (track) begin
            if (!b_rdy && !(cdb.valid && cdb.tag == bt)) begin
                pend_tag.push_back(bt);
                pend_val.push_back(base_v);
            end
            if (is_store && !d_rdy && !(cdb.valid && cdb.tag == dt)) begin
                pend_tag.push_back(dt);
                pend_val.push_back(data_v);
            end
            addr = base_v + {{20{off[11]}}, off};
            if (is_store) begin
                model_mem[addr[7:2]] = data_v;
                commit_q.push_back(next_rob);
            end else begin
                exp_tag.push_back(next_rob);
                exp_val.push_back(model_mem[addr[7:2]]);
            end
        end
        next_rob += 5'd1;
        @(negedge clk);
        dispatch_valid = 1'b0;
        cdb.valid      = 1'b0;
    endtask

    task automatic commit_one();
        commit_valid = 1'b1;
        commit_tag   = commit_q.pop_front();
        @(negedge clk);
        commit_valid = 1'b0;
    endtask

    task automatic wake_one();
        cdb.valid = 1'b1;
        cdb.tag   = pend_tag.pop_front();
        cdb.value = pend_val.pop_front();
        @(negedge clk);
        cdb.valid = 1'b0;
    endtask

    // frees the queue head whenever dispatch is blocked.
    task automatic unblock();
        int t;
        t = 0;
        while (!dispatch_ready) begin
            t++;
            if (t > TIMEOUT) give_up("queue to accept again");
            if (pend_tag.size() > 0) wake_one();
            else if (commit_q.size() > 0) commit_one();
            else idle(1);
        end
    endtask

    task automatic drain();
        int t;
        while (commit_q.size() > 0) commit_one();
        while (pend_tag.size() > 0) wake_one();
        t = 0;
        while (exp_tag.size() > 0) begin
            t++;
            if (t > TIMEOUT) give_up("outstanding writebacks");
            @(negedge clk);
        end
        idle(4);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        int          seen;
        int          t;
        rnd_state = 32'hb2db;
        bp_state  = 32'hb2db; // own stream for wb_ready.
        bp_en = 1'b0;
        wb_count = 0;
        next_rob = '0;
        next_tag = '0;
        for (int i = 0; i < lsq_pkg::MEM_WORDS; i++) model_mem[i] = '0;
        flush = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_insn = '0;
        cdb = '0;
        commit_valid = 1'b0;
        commit_tag = '0;
        wb_ready = 1'b1;
        t = 0;
        while (arst_n !== 1'b1) begin
            t++;
            if (t > TIMEOUT) give_up("reset release");
            @(posedge clk);
        end
        @(negedge clk);

        check("dispatch_ready", 32'(dispatch_ready), 32'd1);
        check("wb_valid", 32'(wb_valid), 32'd0);
        send_op(1'b0, 32'h40, 0, 12'h004, 1, 1, 0, 0, 1);
        send_op(1'b0, 32'h10, 0, 12'hffc, 1, 1, 0, 0, 1);
        drain();

        // load to a stored word waits for the store commit.
        send_op(1'b1, 32'h20, 32'hcafe_0001, 12'h008, 1, 1, 0, 0, 1);
        send_op(1'b0, 32'h28, 0, 12'h000, 1, 1, 0, 0, 1);
        seen = wb_count;
        idle(10);
        check("wb_count", wb_count, seen);
        drain();

        // dispatch cycle cdb wakes one operand only.
        send_op(1'b1, 32'h30, 32'h1234_5678, 12'h000, 0, 0, 1, 0, 1);
        send_op(1'b1, 32'h34, 32'h8765_4321, 12'h000, 0, 0, 0, 1, 1);
        send_op(1'b0, 32'h30, 0, 12'h000, 0, 1, 1, 0, 1);
        send_op(1'b0, 32'h34, 0, 12'h000, 0, 1, 0, 0, 1);
        drain();

        // fill behind an uncommitted head store.
        send_op(1'b1, 32'h00, 32'h0bad_f00d, 12'h000, 1, 1, 0, 0, 1);
        for (int i = 1; i < lsq_pkg::LSQ_DEPTH; i++) begin
            send_op(1'b0, 32'(i * 4), 0, 12'h000, 1, 1, 0, 0, 1);
        end
        check("dispatch_ready", 32'(dispatch_ready), 32'd0);
        commit_one();
        unblock();
        drain();

        bp_en = 1'b1;
        for (int n = 0; n < 80; n++) begin
            unblock();
            get_bits(9, r);
            get_bits(32, d);
            send_op(r[0], {r[3:1], 2'b00}, d, 12'(int'(r[5:4]) * 4 - 4),
                    r[6], r[7], r[8], r[8], 1);
            get_bits(2, r);
            if (r[0] && pend_tag.size() > 0) wake_one();
            if (r[1] && commit_q.size() > 0) commit_one();
        end
        drain();
        bp_en = 1'b0;

        // flush of waiting loads.
        for (int i = 0; i < 3; i++) send_op(1'b0, 32'h0, 0, 12'h000, 0, 1, 0, 0, 0);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        idle(12);
        send_op(1'b1, 32'h3c, 32'h5555_aaaa, 12'h000, 1, 0, 0, 0, 1);
        send_op(1'b0, 32'h3c, 0, 12'h000, 0, 1, 0, 0, 1);
        drain();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: src.f
lsq_pkg.sv
ls_queue.sv
ls_unit.sv
data_mem.sv
lsq_top.sv
lsq_tb_clk.sv
lsq_assert.sv
lsq_tb.sv

// File: Bender.yml
package:
  name: lsq

sources:
  - lsq_pkg.sv
  - ls_queue.sv
  - ls_unit.sv
  - data_mem.sv
  - lsq_top.sv
  - target: test
    files:
      - lsq_tb_clk.sv
      - lsq_assert.sv
      - lsq_tb.sv
